//--- source/safe_domain_cfg.svh
/*
 * size definitions for the always-on safe domain
 * include in any file that needs the pad count or field widths
 */

`ifndef SAFE_DOMAIN_CFG_SVH
`define SAFE_DOMAIN_CFG_SVH

// ********************
// pad array
// number of bidirectional pads, also the width of every function bus
`define SD_N_IO        8
// pad function select width
`define SD_NBIT_PADMUX 2
// pad configuration width, the low bits of the config view
`define SD_NBIT_PADCFG 6

// ********************
// clocking
// ref clock cycles per slow clock period, keep it even
`define SD_SLOW_DIV    4

`endif

//--- source/safe_domain_pkg.sv
/*
 * types shared by the safe domain RTL and its testbench
 * the config write byte is read either as a mux field or a pad config field
 */

`include "safe_domain_cfg.svh"

package safe_domain_pkg;

  // pad function select
  // OFF parks the pad with output and enable low
  typedef enum logic [`SD_NBIT_PADMUX-1:0] {
    PERIO  = 2'd0,
    GPIO   = 2'd1,
    FPGAIO = 2'd2,
    OFF    = 2'd3
  } pad_func_e;

  // mux view, function sits in the low bits
  typedef struct packed {
    logic [5:0] unused;
    pad_func_e  func;
  } pad_mux_fields_t;

  // config view, low six bits go to the pad
  typedef struct packed {
    logic [1:0] unused;
    logic       pull_up;
    logic       pull_down;
    logic [1:0] drive;
    logic       schmitt;
    logic       wake_en;
  } pad_cfg_fields_t;

  // address bit 3 picks the view, 0 for mux and 1 for config
  typedef union packed {
    pad_mux_fields_t mux;
    pad_cfg_fields_t cfg;
  } cfg_word_u;

endpackage

//--- source/clk_rst_gen.sv
/*
 * reset synchronizer and slow clock divider on the reference clock
 * rst_n_o is the reset for every register of the safe domain
 */

`timescale 1ns/100ps

`include "safe_domain_cfg.svh"

module clk_rst_gen (
  input  logic ref_clk_i,
  input  logic rst_n_i,
  output logic rst_n_o,
  output logic slow_clk_o
);

  // half period of the slow clock in ref cycles
  localparam int unsigned HALF_DIV = `SD_SLOW_DIV / 2;
  localparam int unsigned CNT_W    = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;

  logic             rst_meta;
  logic [CNT_W-1:0] div_cnt;

  // ********************
  // reset synchronizer
  // asserts at once, releases on the second edge
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_meta <= 1'b0;
      rst_n_o  <= 1'b0;
    end else begin
      rst_meta <= 1'b1;
      rst_n_o  <= rst_meta;
    end
  end

  // ********************
  // slow clock divider
  // toggle every HALF_DIV ref cycles, low while in reset
  always_ff @(posedge ref_clk_i or negedge rst_n_o) begin
    if (!rst_n_o) begin
      div_cnt    <= '0;
      slow_clk_o <= 1'b0;
    end else if (div_cnt == CNT_W'(HALF_DIV - 1)) begin
      div_cnt    <= '0;
      slow_clk_o <= ~slow_clk_o;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // domain reset never lags the pin reset on assertion
  rst_async_a: assert property (@(posedge ref_clk_i) !rst_n_i |-> !rst_n_o);

endmodule

//--- source/pad_cfg_regs.sv
/*
 * pad register bank behind a four-phase req/ack write port
 * holds one function select and one pad config per pad
 */

`timescale 1ns/100ps

`include "safe_domain_cfg.svh"

module pad_cfg_regs (
  input  logic                                           ref_clk_i,
  input  logic                                           rst_n_i,
  input  logic                                           cfg_req_i,
  input  logic [3:0]                                     cfg_addr_i,
  input  safe_domain_pkg::cfg_word_u                     cfg_wdata_i,
  output logic                                           cfg_ack_o,
  output safe_domain_pkg::pad_func_e [`SD_N_IO-1:0]      pad_mux_o,
  output logic [`SD_N_IO-1:0][`SD_NBIT_PADCFG-1:0]       pad_cfg_o
);

  logic       wr_en;
  logic       wr_kind;
  logic [2:0] wr_pad;

  // ********************
  // address decode
  // bit 3 is the view, bits 2:0 the pad
  assign wr_kind = cfg_addr_i[3];
  assign wr_pad  = cfg_addr_i[2:0];

  // write once per request, on the edge that first sees req
  assign wr_en = cfg_req_i & ~cfg_ack_o;

  // ********************
  // handshake, slave side
  // ack follows req one edge later in both directions
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_ack_o <= 1'b0;
    end else begin
      cfg_ack_o <= cfg_req_i;
    end
  end

  // ********************
  // register bank
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `SD_N_IO; i++) begin
        pad_mux_o[i] <= safe_domain_pkg::OFF;
        pad_cfg_o[i] <= '0;
      end
    end else if (wr_en) begin
      if (!wr_kind) begin
        // mux view, only the function field counts
        pad_mux_o[wr_pad] <= cfg_wdata_i.mux.func;
      end else begin
        // config view, repacked in pad order
        pad_cfg_o[wr_pad] <= {cfg_wdata_i.cfg.pull_up,
                              cfg_wdata_i.cfg.pull_down,
                              cfg_wdata_i.cfg.drive,
                              cfg_wdata_i.cfg.schmitt,
                              cfg_wdata_i.cfg.wake_en};
      end
    end
  end

  // ********************
  // protocol checks
  // master holds address and data until the write is acked
  req_stable_a: assert property (
    @(posedge ref_clk_i) disable iff (!rst_n_i)
    (cfg_req_i && !cfg_ack_o) ##1 cfg_req_i |->
      $stable(cfg_addr_i) && $stable(cfg_wdata_i)
  );

endmodule

//--- source/pad_cell.sv
/*
 * output side of one pad, purely combinational
 * picks out and oe from the selected function and masks the drive when parked
 */

`timescale 1ns/100ps

`include "safe_domain_cfg.svh"

module pad_cell (
  input  safe_domain_pkg::pad_func_e   func_i,
  input  logic [`SD_NBIT_PADCFG-1:0]   cfg_i,
  input  logic                         perio_out_i,
  input  logic                         perio_oe_i,
  input  logic                         gpio_out_i,
  input  logic                         gpio_oe_i,
  input  logic                         fpgaio_out_i,
  input  logic                         fpgaio_oe_i,
  output logic                         io_out_o,
  output logic                         io_oe_o,
  output logic [`SD_NBIT_PADCFG-1:0]   pad_cfg_o
);

  // padding from the pad config up to a full config word
  localparam int unsigned PAD_W = $bits(safe_domain_pkg::pad_cfg_fields_t) - `SD_NBIT_PADCFG;

  safe_domain_pkg::pad_cfg_fields_t cfg_view;
  logic                             parked;

  assign cfg_view = {{PAD_W{1'b0}}, cfg_i};
  assign parked   = (func_i == safe_domain_pkg::OFF);

  // output mux
  always_comb begin
    unique case (func_i)
      safe_domain_pkg::PERIO:  {io_out_o, io_oe_o} = {perio_out_i, perio_oe_i};
      safe_domain_pkg::GPIO:   {io_out_o, io_oe_o} = {gpio_out_i, gpio_oe_i};
      safe_domain_pkg::FPGAIO: {io_out_o, io_oe_o} = {fpgaio_out_i, fpgaio_oe_i};
      default:                 {io_out_o, io_oe_o} = 2'b00;
    endcase
  end

  // pulls and schmitt pass, drive strength zero while OFF
  assign pad_cfg_o = {cfg_view.pull_up,
                      cfg_view.pull_down,
                      parked ? 2'b00 : cfg_view.drive,
                      cfg_view.schmitt,
                      cfg_view.wake_en};

endmodule

//--- source/pad_in_collect.sv
/*
 * input side of the pad array
 * synchronizes io_in_i, steers each bit to the selected function bus
 * and raises a one cycle GPIO wake pulse on an enabled pad edge
 */

`timescale 1ns/100ps

`include "safe_domain_cfg.svh"

module pad_in_collect (
  input  logic                                       ref_clk_i,
  input  logic                                       rst_n_i,
  input  logic [`SD_N_IO-1:0]                        io_in_i,
  input  safe_domain_pkg::pad_func_e [`SD_N_IO-1:0]  pad_mux_i,
  input  logic [`SD_N_IO-1:0]                        wake_en_i,
  output logic [`SD_N_IO-1:0]                        perio_in_o,
  output logic [`SD_N_IO-1:0]                        gpio_in_o,
  output logic [`SD_N_IO-1:0]                        fpgaio_in_o,
  output logic                                       gpio_wake_o
);

  logic [`SD_N_IO-1:0] in_meta;
  logic [`SD_N_IO-1:0] in_sync;
  logic [`SD_N_IO-1:0] in_prev;
  logic [`SD_N_IO-1:0] sel_perio;
  logic [`SD_N_IO-1:0] sel_gpio;
  logic [`SD_N_IO-1:0] sel_fpgaio;
  logic [`SD_N_IO-1:0] wake_hit;

  // ********************
  // two flop synchronizer
  // in_prev is one more stage for edge detect
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_meta <= '0;
      in_sync <= '0;
      in_prev <= '0;
    end else begin
      in_meta <= io_in_i;
      in_sync <= in_meta;
      in_prev <= in_sync;
    end
  end

  // per pad function decode
  always_comb begin
    for (int i = 0; i < `SD_N_IO; i++) begin
      sel_perio[i]  = (pad_mux_i[i] == safe_domain_pkg::PERIO);
      sel_gpio[i]   = (pad_mux_i[i] == safe_domain_pkg::GPIO);
      sel_fpgaio[i] = (pad_mux_i[i] == safe_domain_pkg::FPGAIO);
    end
  end

  // ********************
  // steering, unselected buses read zero
  assign perio_in_o  = in_sync & sel_perio;
  assign gpio_in_o   = in_sync & sel_gpio;
  assign fpgaio_in_o = in_sync & sel_fpgaio;

  // any edge on a wake enabled gpio pad
  assign wake_hit = (in_sync ^ in_prev) & sel_gpio & wake_en_i;

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_wake_o <= 1'b0;
    end else begin
      gpio_wake_o <= |wake_hit;
    end
  end

  // no wake pulse while no pad is in GPIO mode
  wake_needs_gpio_a: assert property (
    @(posedge ref_clk_i) disable iff (!rst_n_i)
    gpio_wake_o |-> |sel_gpio
  );

endmodule

//--- source/safe_domain.sv
/*
 * always-on safe domain top level
 * reset and slow clock, pad register bank, pad cells and input collector
 * pads are programmed through the cfg_req_i / cfg_ack_o write port
 */

`timescale 1ns/100ps

`include "safe_domain_cfg.svh"

module safe_domain (
  input  logic                                    ref_clk_i,
  input  logic                                    rst_n_i,
  output logic                                    rst_n_o,
  output logic                                    slow_clk_o,

  // configuration write port
  input  logic                                    cfg_req_i,
  input  logic [3:0]                              cfg_addr_i,
  input  safe_domain_pkg::cfg_word_u              cfg_wdata_i,
  output logic                                    cfg_ack_o,

  // pads
  output logic [`SD_N_IO-1:0]                     io_out_o,
  input  logic [`SD_N_IO-1:0]                     io_in_i,
  output logic [`SD_N_IO-1:0]                     io_oe_o,
  output logic [`SD_N_IO-1:0][`SD_NBIT_PADCFG-1:0] pad_cfg_o,

  // peripheral I/O
  input  logic [`SD_N_IO-1:0]                     perio_out_i,
  output logic [`SD_N_IO-1:0]                     perio_in_o,
  input  logic [`SD_N_IO-1:0]                     perio_oe_i,

  // GPIO
  input  logic [`SD_N_IO-1:0]                     gpio_out_i,
  output logic [`SD_N_IO-1:0]                     gpio_in_o,
  input  logic [`SD_N_IO-1:0]                     gpio_oe_i,

  // FPGA I/O
  input  logic [`SD_N_IO-1:0]                     fpgaio_out_i,
  output logic [`SD_N_IO-1:0]                     fpgaio_in_o,
  input  logic [`SD_N_IO-1:0]                     fpgaio_oe_i,

  output logic                                    gpio_wake_o
);

  localparam int unsigned PAD_W = $bits(safe_domain_pkg::pad_cfg_fields_t) - `SD_NBIT_PADCFG;

  safe_domain_pkg::pad_func_e [`SD_N_IO-1:0]  s_pad_mux;
  logic [`SD_N_IO-1:0][`SD_NBIT_PADCFG-1:0]   s_pad_cfg;
  logic [`SD_N_IO-1:0]                        s_wake_en;

  // ********************
  // clock and reset
  clk_rst_gen clk_rst_gen_inst (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (rst_n_i),
    .rst_n_o    (rst_n_o),
    .slow_clk_o (slow_clk_o)
  );

  // ********************
  // pad register bank, runs on the synchronized reset
  pad_cfg_regs pad_cfg_regs_inst (
    .ref_clk_i   (ref_clk_i),
    .rst_n_i     (rst_n_o),
    .cfg_req_i   (cfg_req_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_ack_o   (cfg_ack_o),
    .pad_mux_o   (s_pad_mux),
    .pad_cfg_o   (s_pad_cfg)
  );

  // ********************
  // one cell per pad
  for (genvar i = 0; i < `SD_N_IO; i++) begin : gen_pad
    safe_domain_pkg::pad_cfg_fields_t cfg_view;

    // wake enable taken from the raw register, not the masked pad config
    assign cfg_view     = {{PAD_W{1'b0}}, s_pad_cfg[i]};
    assign s_wake_en[i] = cfg_view.wake_en;

    pad_cell pad_cell_inst (
      .func_i       (s_pad_mux[i]),
      .cfg_i        (s_pad_cfg[i]),
      .perio_out_i  (perio_out_i[i]),
      .perio_oe_i   (perio_oe_i[i]),
      .gpio_out_i   (gpio_out_i[i]),
      .gpio_oe_i    (gpio_oe_i[i]),
      .fpgaio_out_i (fpgaio_out_i[i]),
      .fpgaio_oe_i  (fpgaio_oe_i[i]),
      .io_out_o     (io_out_o[i]),
      .io_oe_o      (io_oe_o[i]),
      .pad_cfg_o    (pad_cfg_o[i])
    );
  end

  // ********************
  // input side
  pad_in_collect pad_in_collect_inst (
    .ref_clk_i   (ref_clk_i),
    .rst_n_i     (rst_n_o),
    .io_in_i     (io_in_i),
    .pad_mux_i   (s_pad_mux),
    .wake_en_i   (s_wake_en),
    .perio_in_o  (perio_in_o),
    .gpio_in_o   (gpio_in_o),
    .fpgaio_in_o (fpgaio_in_o),
    .gpio_wake_o (gpio_wake_o)
  );

endmodule

//--- tests/tb_clk_gen.sv
/*
 * clock and reset source for the safe domain testbench
 * 100 ns reference clock, reset low for the first 3 cycles
 */

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD = 50,
  parameter int unsigned RST_CYCLES  = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  // free running reference clock
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // reset low from time 0, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- tests/safe_domain_checker.sv
/*
 * result checker for the safe domain testbench
 * compares DUT outputs with expected values on each check strobe,
 * watches reset and the slow clock, prints the closing counts
 */

`timescale 1ns/100ps

`include "safe_domain_cfg.svh"

module safe_domain_checker #(
  parameter int N     = `SD_N_IO,
  parameter int CFG_W = `SD_N_IO * `SD_NBIT_PADCFG
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             check_i,
  input  logic             done_i,
  input  int               test_id_i,
  // observed DUT outputs
  input  logic             dut_rst_n_i,
  input  logic             slow_clk_i,
  input  logic             cfg_ack_i,
  input  logic [N-1:0]     io_out_i,
  input  logic [N-1:0]     io_oe_i,
  input  logic [CFG_W-1:0] pad_cfg_i,
  input  logic [N-1:0]     perio_in_i,
  input  logic [N-1:0]     gpio_in_i,
  input  logic [N-1:0]     fpgaio_in_i,
  input  logic             gpio_wake_i,
  // expected values for the current strobe
  input  logic [N-1:0]     exp_io_out_i,
  input  logic [N-1:0]     exp_io_oe_i,
  input  logic [CFG_W-1:0] exp_pad_cfg_i,
  input  logic [N-1:0]     exp_perio_in_i,
  input  logic [N-1:0]     exp_gpio_in_i,
  input  logic [N-1:0]     exp_fpgaio_in_i,
  input  logic             exp_wake_i,
  output int               fail_cnt_o
);

  int   n_tests = 0;
  int   n_failed = 0;
  int   test_errs = 0;
  int   mon_errs = 0;
  int   end_errs = 0;
  int   slow_cnt = 0;
  int   slow_rises = 0;
  logic slow_prev = 1'b0;
  logic rst_seen = 1'b0;

  assign fail_cnt_o = n_failed + mon_errs + end_errs;

  task automatic compare(input string sig, input logic [CFG_W-1:0] got,
                         input logic [CFG_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, sig, got, exp);
      test_errs++;
    end
  endtask

  // ********************
  // strobed compare
  // sampled on the rising edge, inputs settled since the falling edge
  always @(posedge clk_i) begin
    if (check_i) begin
      test_errs = 0;
      compare("cfg_ack_o", CFG_W'(cfg_ack_i), '0);
      compare("io_out_o", CFG_W'(io_out_i), CFG_W'(exp_io_out_i));
      compare("io_oe_o", CFG_W'(io_oe_i), CFG_W'(exp_io_oe_i));
      compare("pad_cfg_o", pad_cfg_i, exp_pad_cfg_i);
      compare("perio_in_o", CFG_W'(perio_in_i), CFG_W'(exp_perio_in_i));
      compare("gpio_in_o", CFG_W'(gpio_in_i), CFG_W'(exp_gpio_in_i));
      compare("fpgaio_in_o", CFG_W'(fpgaio_in_i), CFG_W'(exp_fpgaio_in_i));
      compare("gpio_wake_o", CFG_W'(gpio_wake_i), CFG_W'(exp_wake_i));
      n_tests++;
      if (test_errs == 0) begin
        $display("test %0d: ok", test_id_i);
      end else begin
        $display("test %0d: %0d mismatches", test_id_i, test_errs);
        n_failed++;
      end
    end
  end

  // ********************
  // reset and slow clock watch
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      // skip the first edge, the domain reset may still be settling
      if (rst_seen && dut_rst_n_i !== 1'b0) begin
        $display("MISMATCH at %0t ns: rst_n_o is %b, expected 0", $time, dut_rst_n_i);
        mon_errs++;
      end
      rst_seen = 1'b1;
    end else if (dut_rst_n_i === 1'b1) begin
      slow_cnt++;
      if (slow_clk_i === 1'b1 && slow_prev === 1'b0) begin
        // period measured between two sampled rising edges
        if (slow_rises > 0 && slow_cnt != `SD_SLOW_DIV) begin
          $display("MISMATCH at %0t ns: slow_clk_o period is %0d, expected %0d",
                   $time, slow_cnt, `SD_SLOW_DIV);
          mon_errs++;
        end
        slow_rises++;
        slow_cnt = 0;
      end
      slow_prev = slow_clk_i;
    end
  end

  // closing counts
  always @(posedge done_i) begin
    if (slow_rises < 2) begin
      $display("error: slow_clk_o never completed a full period");
      end_errs++;
    end
    $display("%0d tests run, %0d with mismatches, %0d monitor errors",
             n_tests, n_failed, mon_errs + end_errs);
  end

endmodule

//--- tests/safe_domain_tb.sv
/*
 * testbench for the safe domain
 * builds a table of pad writes and port patterns with predicted outputs,
 * then plays it through the four-phase config port one entry at a time
 */

`timescale 1ns/100ps

`include "safe_domain_cfg.svh"

module safe_domain_tb;

  localparam int N           = `SD_N_IO;
  localparam int CW          = `SD_NBIT_PADCFG;
  localparam int CFG_W       = N * CW;
  localparam int MAX_TESTS   = 32;
  localparam int ACK_TIMEOUT = 16;
  localparam int RST_TIMEOUT = 10;

  logic clk;
  logic rst_n;

  // DUT ports
  logic                       dut_rst_n;
  logic                       slow_clk;
  logic                       cfg_req;
  logic [3:0]                 cfg_addr;
  safe_domain_pkg::cfg_word_u cfg_wdata;
  logic                       cfg_ack;
  logic [N-1:0]               io_out;
  logic [N-1:0]               io_in;
  logic [N-1:0]               io_oe;
  logic [N-1:0][CW-1:0]       pad_cfg;
  logic [N-1:0]               func_out[3];
  logic [N-1:0]               func_oe[3];
  logic [N-1:0]               func_in[3];
  logic                       gpio_wake;

  // checker strobe and expected values
  logic             check;
  logic             done;
  int               test_id;
  int               fail_cnt;
  logic             timed_out;
  logic [N-1:0]     exp_out;
  logic [N-1:0]     exp_oe;
  logic [CFG_W-1:0] exp_cfg;
  logic [N-1:0]     exp_in[3];
  logic             exp_wake;

  // ********************
  // stimulus table, function index follows the enum (PERIO, GPIO, FPGAIO)
  int                         n_entries;
  int                         seed;
  logic                       t_wr[MAX_TESTS];
  logic [3:0]                 t_addr[MAX_TESTS];
  safe_domain_pkg::cfg_word_u t_wdata[MAX_TESTS];
  logic [N-1:0]               t_out[MAX_TESTS][3];
  logic [N-1:0]               t_oe[MAX_TESTS][3];
  logic [N-1:0]               t_in[MAX_TESTS];
  logic [N-1:0]               t_exp_out[MAX_TESTS];
  logic [N-1:0]               t_exp_oe[MAX_TESTS];
  logic [CFG_W-1:0]           t_exp_cfg[MAX_TESTS];
  logic [N-1:0]               t_exp_in[MAX_TESTS][3];
  logic                       t_exp_wake[MAX_TESTS];

  // reference state of the pad bank
  safe_domain_pkg::pad_func_e mux_m[N];
  logic [CW-1:0]              cfg_m[N];
  logic [N-1:0]               prev_in;

  tb_clk_gen tb_clk_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  safe_domain safe_domain_inst (
    .ref_clk_i    (clk),
    .rst_n_i      (rst_n),
    .rst_n_o      (dut_rst_n),
    .slow_clk_o   (slow_clk),
    .cfg_req_i    (cfg_req),
    .cfg_addr_i   (cfg_addr),
    .cfg_wdata_i  (cfg_wdata),
    .cfg_ack_o    (cfg_ack),
    .io_out_o     (io_out),
    .io_in_i      (io_in),
    .io_oe_o      (io_oe),
    .pad_cfg_o    (pad_cfg),
    .perio_out_i  (func_out[0]),
    .perio_in_o   (func_in[0]),
    .perio_oe_i   (func_oe[0]),
    .gpio_out_i   (func_out[1]),
    .gpio_in_o    (func_in[1]),
    .gpio_oe_i    (func_oe[1]),
    .fpgaio_out_i (func_out[2]),
    .fpgaio_in_o  (func_in[2]),
    .fpgaio_oe_i  (func_oe[2]),
    .gpio_wake_o  (gpio_wake)
  );

  safe_domain_checker safe_domain_checker_inst (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .check_i         (check),
    .done_i          (done),
    .test_id_i       (test_id),
    .dut_rst_n_i     (dut_rst_n),
    .slow_clk_i      (slow_clk),
    .cfg_ack_i       (cfg_ack),
    .io_out_i        (io_out),
    .io_oe_i         (io_oe),
    .pad_cfg_i       (pad_cfg),
    .perio_in_i      (func_in[0]),
    .gpio_in_i       (func_in[1]),
    .fpgaio_in_i     (func_in[2]),
    .gpio_wake_i     (gpio_wake),
    .exp_io_out_i    (exp_out),
    .exp_io_oe_i     (exp_oe),
    .exp_pad_cfg_i   (exp_cfg),
    .exp_perio_in_i  (exp_in[0]),
    .exp_gpio_in_i   (exp_in[1]),
    .exp_fpgaio_in_i (exp_in[2]),
    .exp_wake_i      (exp_wake),
    .fail_cnt_o      (fail_cnt)
  );

  // write words through the two union views, unused bits set to show they are ignored
  function automatic safe_domain_pkg::cfg_word_u mux_word(input safe_domain_pkg::pad_func_e f);
    safe_domain_pkg::cfg_word_u w;
    w.mux.unused = 6'h15;
    w.mux.func   = f;
    return w;
  endfunction

  function automatic safe_domain_pkg::cfg_word_u cfg_word(input logic pu, input logic pd,
                                                          input logic [1:0] drv,
                                                          input logic sch, input logic wk);
    safe_domain_pkg::cfg_word_u w;
    w.cfg.unused    = 2'b11;
    w.cfg.pull_up   = pu;
    w.cfg.pull_down = pd;
    w.cfg.drive     = drv;
    w.cfg.schmitt   = sch;
    w.cfg.wake_en   = wk;
    return w;
  endfunction

  // ********************
  // append one entry and predict every output from the routing rules
  task automatic add_entry(input logic wr, input logic [3:0] addr,
                           input safe_domain_pkg::cfg_word_u word, input logic [N-1:0] in);
    int k;
    int f;
    int i;
    logic [CW-1:0] slice;
    k = n_entries;
    t_wr[k]    = wr;
    t_addr[k]  = addr;
    t_wdata[k] = word;
    t_in[k]    = in;
    for (f = 0; f < 3; f++) begin
      t_out[k][f]    = N'($random(seed));
      t_oe[k][f]     = N'($random(seed));
      t_exp_in[k][f] = '0;
    end
    // bank update, kind bit picks the view
    if (wr && !addr[3]) begin
      mux_m[addr[2:0]] = word.mux.func;
    end else if (wr) begin
      cfg_m[addr[2:0]] = {word.cfg.pull_up, word.cfg.pull_down, word.cfg.drive,
                          word.cfg.schmitt, word.cfg.wake_en};
    end
    t_exp_out[k]  = '0;
    t_exp_oe[k]   = '0;
    t_exp_wake[k] = 1'b0;
    for (i = 0; i < N; i++) begin
      f     = int'(mux_m[i]);
      slice = cfg_m[i];
      if (mux_m[i] == safe_domain_pkg::OFF) begin
        // parked pad, drive strength forced to 0
        slice[3:2] = 2'b00;
      end else begin
        t_exp_out[k][i]   = t_out[k][f][i];
        t_exp_oe[k][i]    = t_oe[k][f][i];
        t_exp_in[k][f][i] = in[i];
      end
      // wake_en is the low config bit
      if (mux_m[i] == safe_domain_pkg::GPIO && cfg_m[i][0] && in[i] != prev_in[i]) begin
        t_exp_wake[k] = 1'b1;
      end
      t_exp_cfg[k][i*CW +: CW] = slice;
    end
    prev_in   = in;
    n_entries = n_entries + 1;
  endtask

  task automatic build_table();
    int f;
    for (f = 0; f < N; f++) begin
      mux_m[f] = safe_domain_pkg::OFF;
      cfg_m[f] = '0;
    end
    prev_in   = '0;
    n_entries = 0;
    // reset state, all pads OFF
    add_entry(1'b0, 4'h0, '0, 8'hA5);
    // config on pad 2 while still OFF, then route it
    add_entry(1'b1, 4'hA, cfg_word(1'b1, 1'b0, 2'd3, 1'b1, 1'b0), 8'hA5);
    add_entry(1'b1, 4'h2, mux_word(safe_domain_pkg::PERIO), 8'h5A);
    add_entry(1'b1, 4'h0, mux_word(safe_domain_pkg::GPIO), 8'h5A);
    add_entry(1'b1, 4'h5, mux_word(safe_domain_pkg::FPGAIO), 8'h3C);
    add_entry(1'b1, 4'h7, mux_word(safe_domain_pkg::PERIO), 8'hC3);
    // wake on pad 0, GPIO with wake_en
    add_entry(1'b1, 4'h8, cfg_word(1'b0, 1'b1, 2'd1, 1'b0, 1'b1), 8'hC3);
    add_entry(1'b0, 4'h0, '0, 8'hC2);
    // pad 1 GPIO without wake_en, toggle gives no pulse
    add_entry(1'b1, 4'h1, mux_word(safe_domain_pkg::GPIO), 8'hC2);
    add_entry(1'b0, 4'h0, '0, 8'hC0);
    // pad 3 wake_en set but in PERIO
    add_entry(1'b1, 4'hB, cfg_word(1'b0, 1'b0, 2'd2, 1'b1, 1'b1), 8'hC0);
    add_entry(1'b1, 4'h3, mux_word(safe_domain_pkg::PERIO), 8'hC0);
    add_entry(1'b0, 4'h0, '0, 8'hC8);
    // pad 4 through every function
    for (f = 0; f < 4; f++) begin
      add_entry(1'b1, 4'h4, mux_word(safe_domain_pkg::pad_func_e'(f)), N'($random(seed)));
    end
    // park pad 0, its drive drops
    add_entry(1'b1, 4'h0, mux_word(safe_domain_pkg::OFF), 8'h01);
    for (f = 0; f < 4; f++) begin
      add_entry(1'b0, 4'h0, '0, N'($random(seed)));
    end
  endtask

  // ********************
  // handshake waits, sampled on the falling edge
  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (cfg_ack !== level && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (cfg_ack !== level) begin
      $display("timeout at %0t ns: cfg_ack_o did not go to %b within %0d cycles",
               $time, level, ACK_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_entry(input int k);
    if (t_wr[k]) begin
      cfg_addr  = t_addr[k];
      cfg_wdata = t_wdata[k];
      cfg_req   = 1'b1;
      wait_ack(1'b1);
      cfg_req = 1'b0;
      if (!timed_out) begin
        wait_ack(1'b0);
      end
    end
    if (!timed_out) begin
      func_out = t_out[k];
      func_oe  = t_oe[k];
      io_in    = t_in[k];
      // two sync edges, then the wake flop
      repeat (3) @(negedge clk);
      exp_out  = t_exp_out[k];
      exp_oe   = t_exp_oe[k];
      exp_cfg  = t_exp_cfg[k];
      exp_in   = t_exp_in[k];
      exp_wake = t_exp_wake[k];
      test_id  = k;
      check    = 1'b1;
      @(negedge clk);
      check = 1'b0;
    end
  endtask

  initial begin : driver
    int n;
    int k;
    seed      = 32'h08c31741;
    timed_out = 1'b0;
    check     = 1'b0;
    done      = 1'b0;
    test_id   = 0;
    cfg_req   = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    io_in     = '0;
    for (k = 0; k < 3; k++) begin
      func_out[k] = '0;
      func_oe[k]  = '0;
      exp_in[k]   = '0;
    end
    exp_out  = '0;
    exp_oe   = '0;
    exp_cfg  = '0;
    exp_wake = 1'b0;
    build_table();

    // pin reset release, seen on a rising edge
    n = 0;
    while (rst_n !== 1'b1 && n < RST_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout at %0t ns: reset pin was never released", $time);
      timed_out = 1'b1;
    end
    // domain reset must follow within 2 edges
    n = 0;
    while (!timed_out && dut_rst_n !== 1'b1 && n < 2) begin
      @(negedge clk);
      n++;
    end
    if (!timed_out && dut_rst_n !== 1'b1) begin
      $display("timeout at %0t ns: rst_n_o still low 2 edges after reset release", $time);
      timed_out = 1'b1;
    end

    for (k = 0; k < n_entries && !timed_out; k++) begin
      run_entry(k);
    end

    done = 1'b1;
    #1;
    if (timed_out || fail_cnt != 0) begin
      $display("tests failed");
    end else begin
      $display("all tests passed");
    end
    $finish;
  end

endmodule

//--- safe_domain.f
+incdir+source
source/safe_domain_pkg.sv
source/clk_rst_gen.sv
source/pad_cfg_regs.sv
source/pad_cell.sv
source/pad_in_collect.sv
source/safe_domain.sv
tests/tb_clk_gen.sv
tests/safe_domain_checker.sv
tests/safe_domain_tb.sv

//--- Makefile
# Verilator build and run of the safe domain testbench

TOP = safe_domain_tb
LOG = sim.log

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f safe_domain.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
